/* src/cpu_bus_defs.svh */
/*
 * Sizes and bit positions of the byte bus
 *   word and address widths, frame length
 *   control byte bits and first address and data phases
 */

`ifndef CPU_BUS_DEFS_SVH
`define CPU_BUS_DEFS_SVH

// Data and address widths of the core
`define CPU_WORD_W 32
`define CPU_ADDR_W 32

// Last phase of a frame, phase 0 is idle
`define FRAME_PHASES 9

// First phase of the address run and of the data run
`define FRAME_ADDR_FIRST 2
`define FRAME_DATA_FIRST 6

// Control byte bits
`define CTRL_WRITE_BIT 0
`define CTRL_START_BIT 7

`endif

/* src/cpu_bus_pkg.sv */
/*
 * Shared types for the accumulator processor
 *   opcode_e    8-bit instruction kinds
 *   instr_u     fetched instruction word, immediate view and memory view
 */

`default_nettype none

package cpu_bus_pkg;

  typedef enum logic [7:0] {
    OP_NOP  = 8'h00,
    OP_LDI  = 8'h01,
    OP_LD   = 8'h02,
    OP_ST   = 8'h03,
    OP_ADD  = 8'h04,
    OP_JMP  = 8'h05,
    OP_JZ   = 8'h06,
    OP_HALT = 8'hff
  } opcode_e;

  typedef struct packed {
    opcode_e     op;     // Bits 31..24
    logic [23:0] imm;    // Sign-extended by LDI
  } instr_imm_t;

  typedef struct packed {
    opcode_e     op;     // Bits 31..24
    logic [3:0]  rsvd;   // Ignored by the core
    logic [19:0] index;  // Word index, byte address is index * 4
  } instr_mem_t;

  typedef union packed {
    instr_imm_t i;       // LDI
    instr_mem_t m;       // LD, ST, ADD, JMP, JZ
  } instr_u;

endpackage

`default_nettype wire

/* src/cpu_mem_if.sv */
/*
 * Memory request link between the core and the byte bus sequencer
 *   core modport drives the request, seq modport answers it
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defs.svh"

interface cpu_mem_if;

  logic                   req;    // Held until ack
  logic                   write;  // 1 for a store
  logic [`CPU_ADDR_W-1:0] addr;   // Byte address
  logic [`CPU_WORD_W-1:0] wdata;
  logic                   ack;    // One cycle, ends the access
  logic [`CPU_WORD_W-1:0] rdata;  // Valid with ack on a read

  modport core (
    output req, write, addr, wdata,
    input  ack, rdata
  );

  modport seq (
    input  req, write, addr, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

/* src/accum_core.sv */
/*
 * Accumulator processor core
 *   fetch, decode, memory access and halt states
 *   program counter, accumulator and latched instruction word
 *   issues word accesses over the cpu_mem_if core modport
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defs.svh"

module accum_core import cpu_bus_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    run,
  cpu_mem_if.core mem,
  output logic    halted
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_DECODE,
    S_MEM,
    S_HALT
  } state_e;

  state_e                 state;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_WORD_W-1:0] acc;
  instr_u                 instr;

  logic                   req_q;
  logic                   write_q;
  logic [`CPU_ADDR_W-1:0] addr_q;
  logic [`CPU_WORD_W-1:0] wdata_q;

  logic [`CPU_ADDR_W-1:0] pc_next;
  logic [`CPU_ADDR_W-1:0] target;
  logic [`CPU_WORD_W-1:0] imm_sext;

  assign mem.req   = req_q;
  assign mem.write = write_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  assign pc_next  = pc + `CPU_ADDR_W'd4;
  assign target   = {{(`CPU_ADDR_W-22){1'b0}}, instr.m.index, 2'b00};  // Word index to bytes
  assign imm_sext = {{(`CPU_WORD_W-24){instr.i.imm[23]}}, instr.i.imm};

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_FETCH;
      pc      <= '0;
      acc     <= '0;
      req_q   <= 1'b0;
      write_q <= 1'b0;
      halted  <= 1'b0;
    end else begin
      case (state)
        S_FETCH: begin
          if (!req_q) begin
            if (run) begin  // Run low holds off a new fetch
              req_q   <= 1'b1;
              write_q <= 1'b0;
              addr_q  <= pc;
            end
          end else if (mem.ack) begin
            req_q <= 1'b0;
            instr <= mem.rdata;
            state <= S_DECODE;
          end
        end

        S_DECODE: begin
          case (instr.i.op)
            OP_LDI: begin
              acc   <= imm_sext;
              pc    <= pc_next;
              state <= S_FETCH;
            end
            OP_LD, OP_ADD, OP_ST: begin
              write_q <= (instr.m.op == OP_ST);  // Operands set up before req rises
              addr_q  <= target;
              wdata_q <= acc;
              state   <= S_MEM;
            end
            OP_JMP: begin
              pc    <= target;
              state <= S_FETCH;
            end
            OP_JZ: begin
              pc    <= (acc == '0) ? target : pc_next;
              state <= S_FETCH;
            end
            OP_HALT: begin
              halted <= 1'b1;
              state  <= S_HALT;
            end
            default: begin  // NOP and undefined codes
              pc    <= pc_next;
              state <= S_FETCH;
            end
          endcase
        end

        S_MEM: begin
          if (!req_q) begin
            if (run) begin
              req_q <= 1'b1;
            end
          end else if (mem.ack) begin
            req_q <= 1'b0;
            pc    <= pc_next;
            state <= S_FETCH;
            case (instr.m.op)
              OP_LD:   acc <= mem.rdata;
              OP_ADD:  acc <= acc + mem.rdata;  // Wraps at 32 bits
              default: ;                        // Store leaves acc alone
            endcase
          end
        end

        default: begin  // S_HALT, left only by reset
          req_q <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/byte_bus_sequencer.sv */
/*
 * Byte bus sequencer
 *   turns each word access into a nine-phase frame on the pins
 *   control byte, four address bytes, four data bytes, LSB first
 *   assembles read words from uio_in and answers with ack
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defs.svh"

module byte_bus_sequencer (
  input  logic       clk,
  input  logic       rst,
  cpu_mem_if.seq     mem,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  logic [3:0]       phase;       // 0 idle, 1 control, 2..5 address, 6..9 data
  logic [3:0]       phase_nxt;
  logic             accept;
  logic             dir_write;   // Direction latched at acceptance
  logic             ack_q;
  logic [3:0][7:0]  rd_lane;     // Read bytes, lane 0 is the LSB
  logic [3:0]       rd_off;
  logic             in_data;

  logic [7:0]       uo_nxt;
  logic [7:0]       uio_nxt;
  logic [7:0]       oe_nxt;
  logic [3:0]       addr_off;
  logic [3:0]       data_off;

  assign accept  = (phase == 4'd0) && mem.req && !ack_q;  // Req still high in the ack cycle
  assign in_data = (phase >= 4'(`FRAME_DATA_FIRST)) && (phase <= 4'(`FRAME_PHASES));
  assign rd_off  = phase - 4'(`FRAME_DATA_FIRST);

  assign mem.ack   = ack_q;
  assign mem.rdata = rd_lane;

  always_comb begin
    if (phase == 4'd0) begin
      phase_nxt = accept ? 4'd1 : 4'd0;
    end else if (phase == 4'(`FRAME_PHASES)) begin
      phase_nxt = 4'd0;
    end else begin
      phase_nxt = phase + 4'd1;
    end
  end

  // Pin bytes for the phase entered at the next edge
  always_comb begin
    uo_nxt   = 8'h00;
    uio_nxt  = 8'h00;
    oe_nxt   = 8'h00;
    addr_off = phase_nxt - 4'(`FRAME_ADDR_FIRST);
    data_off = phase_nxt - 4'(`FRAME_DATA_FIRST);
    case (phase_nxt)
      4'd1: begin
        uo_nxt[`CTRL_START_BIT] = 1'b1;
        uo_nxt[`CTRL_WRITE_BIT] = mem.write;  // Not latched yet on this edge
      end
      4'd2, 4'd3, 4'd4, 4'd5: begin
        uo_nxt = mem.addr[8*addr_off[1:0] +: 8];  // Addr held stable by the core
      end
      4'd6, 4'd7, 4'd8, 4'd9: begin
        if (dir_write) begin
          uio_nxt = mem.wdata[8*data_off[1:0] +: 8];
          oe_nxt  = 8'hff;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase     <= 4'd0;
      dir_write <= 1'b0;
      ack_q     <= 1'b0;
      uo_out    <= 8'h00;
      uio_out   <= 8'h00;
      uio_oe    <= 8'h00;
    end else begin
      phase   <= phase_nxt;
      ack_q   <= (phase == 4'(`FRAME_PHASES));  // Ack with pins back at idle
      uo_out  <= uo_nxt;
      uio_out <= uio_nxt;
      uio_oe  <= oe_nxt;
      if (accept) begin
        dir_write <= mem.write;
      end
    end
  end

  // Read lanes, sampled at the edge that ends each data phase
  always_ff @(posedge clk) begin
    if (in_data && !dir_write) begin
      rd_lane[rd_off[1:0]] <= uio_in;
    end
  end

endmodule

`default_nettype wire

/* src/cpu_handler_top.sv */
/*
 * Top level of the accumulator processor on the byte pins
 *   accum_core and byte_bus_sequencer joined by cpu_mem_if
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_handler_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       run,      // Low holds off new accesses
  output logic [7:0] uo_out,   // Control and address bytes
  input  logic [7:0] uio_in,   // Read data byte
  output logic [7:0] uio_out,  // Write data byte
  output logic [7:0] uio_oe,   // All ones while driving write data
  output logic       halted
);

  cpu_mem_if mem_bus ();

  accum_core u_core (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .mem    (mem_bus.core),
    .halted (halted)
  );

  byte_bus_sequencer u_seq (
    .clk     (clk),
    .rst     (rst),
    .mem     (mem_bus.seq),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock source, 20 ns period
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // Half period
  end

endmodule

`default_nettype wire

/* bench/cpu_handler_properties.sv */
/*
 * Concurrent assertions on the byte pins of cpu_handler_top
 *   output enable levels and write data window
 *   start bit seen once per frame
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defs.svh"

module cpu_handler_properties (
  input logic       clk,
  input logic       rst,
  input logic [7:0] uo_out,
  input logic [7:0] uio_oe
);

  localparam int DATA_POS = `FRAME_DATA_FIRST - 1;  // Position of the first data phase
  localparam int LAST_POS = `FRAME_PHASES - 1;

  logic [3:0] frame_pos;    // Cycles since the control byte, 0 when idle
  logic       frame_write;  // Write bit of the current frame
  logic       in_data_win;

  assign in_data_win = (frame_pos >= DATA_POS) && (frame_pos <= LAST_POS);

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_pos   <= 4'd0;
      frame_write <= 1'b0;
    end else if (frame_pos == 4'd0) begin
      if (uo_out[`CTRL_START_BIT]) begin
        frame_pos   <= 4'd1;
        frame_write <= uo_out[`CTRL_WRITE_BIT];
      end
    end else if (frame_pos == 4'(LAST_POS)) begin
      frame_pos <= 4'd0;
    end else begin
      frame_pos <= frame_pos + 4'd1;
    end
  end

  a_oe_levels: assert property (@(posedge clk) disable iff (rst)
    (uio_oe == 8'h00) || (uio_oe == 8'hff))
    else $error("uio_oe holds a mixed value %h", uio_oe);

  // Driven exactly in the data phases of a write frame
  a_oe_window: assert property (@(posedge clk) disable iff (rst)
    (uio_oe == 8'hff) == (frame_write && in_data_win))
    else $error("uio_oe %h outside the write data window", uio_oe);

  a_start_once: assert property (@(posedge clk) disable iff (rst)
    (frame_pos == 4'd0 && uo_out[`CTRL_START_BIT]) |-> ##5 (uo_out == 8'h00) [*5])
    else $error("uo_out not clear after the address bytes");

endmodule

bind cpu_handler_top cpu_handler_properties u_props (
  .clk    (clk),
  .rst    (rst),
  .uo_out (uo_out),
  .uio_oe (uio_oe)
);

`default_nettype wire

/* bench/cpu_handler_tb.sv */
/*
 * Testbench for cpu_handler_top
 *   pin level memory model that decodes the nine-phase frames
 *   program, expected frame and expected store tables
 *   run low check, store comparison loop and cycle timeout
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defs.svh"

module cpu_handler_tb import cpu_bus_pkg::*; ();

  localparam int MEM_WORDS    = 256;
  localparam int N_FRAMES     = 22;
  localparam int N_STORES     = 4;
  localparam int IDLE_CYCLES  = 20;  // Run held low after reset
  localparam int QUIET_CYCLES = 60;  // Window after halt with no frame allowed
  localparam int CYCLE_LIMIT  = 10 * N_FRAMES * 12;

  logic       clk;
  logic       rst;
  logic       run;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  logic       halted;

  logic [31:0]         mem_words [0:MEM_WORDS-1];
  logic [N_FRAMES-1:0] exp_fr_write;  // Bit i set when frame i is a store
  logic [31:0]         exp_fr_addr [0:N_FRAMES-1];
  logic [31:0]         exp_st_addr [0:N_STORES-1];
  logic [31:0]         exp_st_data [0:N_STORES-1];
  logic [31:0]         obs_st_addr [$];
  logic [31:0]         obs_st_data [$];

  int          seed;
  int          errors    = 0;
  int          cycles    = 0;
  int          frame_cnt = 0;
  int          mphase    = 0;  // Frame phase seen on the pins
  logic        f_write;
  logic [31:0] f_addr;
  logic [31:0] f_data;
  logic [31:0] rd_word;

  tb_clock_gen u_clk (.clk(clk));

  cpu_handler_top uut (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .halted  (halted)
  );

  function automatic logic [31:0] encode_mem(input opcode_e op, input logic [19:0] index);
    return {op, 4'h0, index};
  endfunction

  function automatic logic [31:0] encode_imm(input opcode_e op, input logic [23:0] imm);
    return {op, imm};
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
    mem_words[addr[9:2]] = word;
  endtask

  task automatic build_tables();
    int          i;
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $random(seed);
    r1 = $random(seed);
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_words[i] = 32'hff00_0000 | (i * 4);  // HALT tagged with its byte address
    end
    load_word(32'h000, encode_mem(OP_LD, 20'd64));
    load_word(32'h004, encode_mem(OP_ST, 20'd80));
    load_word(32'h008, encode_imm(OP_LDI, 24'hff_fffb));  // -5
    load_word(32'h00c, encode_mem(OP_ADD, 20'd65));
    load_word(32'h010, encode_mem(OP_ST, 20'd81));
    load_word(32'h014, encode_imm(OP_LDI, 24'hff_fffd));  // -3
    load_word(32'h018, encode_mem(OP_ADD, 20'd66));       // Sum is zero
    load_word(32'h01c, encode_mem(OP_JZ, 20'd10));        // Taken to 0x28
    load_word(32'h028, encode_mem(OP_ST, 20'd82));
    load_word(32'h02c, encode_imm(OP_LDI, 24'd7));
    load_word(32'h030, encode_mem(OP_JZ, 20'd9));         // Not taken
    load_word(32'h034, encode_mem(OP_JMP, 20'd16));       // To 0x40
    load_word(32'h040, encode_mem(OP_ST, 20'd83));
    load_word(32'h044, encode_imm(OP_NOP, 24'd0));
    load_word(32'h048, encode_imm(OP_HALT, 24'd0));
    load_word(32'h100, r0);
    load_word(32'h104, r1);
    load_word(32'h108, 32'd3);
    exp_fr_addr = '{32'h000, 32'h100, 32'h004, 32'h140, 32'h008, 32'h00c,
                    32'h104, 32'h010, 32'h144, 32'h014, 32'h018, 32'h108,
                    32'h01c, 32'h028, 32'h148, 32'h02c, 32'h030, 32'h034,
                    32'h040, 32'h14c, 32'h044, 32'h048};
    exp_fr_write = (22'd1 << 3) | (22'd1 << 8) | (22'd1 << 14) | (22'd1 << 19);
    exp_st_addr = '{32'h140, 32'h144, 32'h148, 32'h14c};
    exp_st_data = '{r0, r1 - 32'd5, 32'd0, 32'd7};  // Minus five wraps at 32 bits
  endtask

  task automatic check_frame();
    if (frame_cnt >= N_FRAMES) begin
      errors++;
      $display("Unexpected frame to address %h after the program ended", f_addr);
    end else begin
      expect_eq($sformatf("frame %0d write", frame_cnt), exp_fr_write[frame_cnt], f_write);
      expect_eq($sformatf("frame %0d addr", frame_cnt), exp_fr_addr[frame_cnt], f_addr);
    end
    frame_cnt++;
  endtask

  // Memory model that follows the frame from the start bit
  always @(negedge clk) begin
    if (rst) begin
      mphase = 0;
    end else begin
      if (mphase == 0 && uo_out[`CTRL_START_BIT]) begin
        mphase = 1;
      end else if (mphase == `FRAME_PHASES) begin
        mphase = 0;
      end else if (mphase != 0) begin
        mphase = mphase + 1;
      end
      uio_in = 8'h00;
      if (mphase == 1) begin
        f_write = uo_out[`CTRL_WRITE_BIT];
        f_addr  = '0;
        expect_eq("control byte", 32'h80 | f_write, uo_out);
      end else if (mphase >= `FRAME_ADDR_FIRST && mphase < `FRAME_DATA_FIRST) begin
        f_addr[8*(mphase-`FRAME_ADDR_FIRST) +: 8] = uo_out;  // LSB first
        if (mphase == `FRAME_DATA_FIRST - 1) begin
          check_frame();
        end
      end else if (mphase >= `FRAME_DATA_FIRST) begin
        expect_eq("uo_out in data phase", 32'h0, uo_out);
        if (f_write) begin
          f_data[8*(mphase-`FRAME_DATA_FIRST) +: 8] = uio_out;
          if (mphase == `FRAME_PHASES) begin
            obs_st_addr.push_back(f_addr);
            obs_st_data.push_back(f_data);
            mem_words[f_addr[9:2]] = f_data;
          end
        end else begin
          rd_word = mem_words[f_addr[9:2]];
          uio_in  = rd_word[8*(mphase-`FRAME_DATA_FIRST) +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d, stores: %0d", errors, obs_st_addr.size());
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int i;
    seed   = 41524;
    rst    = 1'b1;
    run    = 1'b0;
    uio_in = 8'h00;
    build_tables();
    repeat (5) @(negedge clk);
    rst = 1'b0;

    repeat (IDLE_CYCLES) begin  // No activity while run is low
      @(negedge clk);
      expect_eq("run low uo_out", 32'h0, uo_out);
      expect_eq("run low uio_out", 32'h0, uio_out);
      expect_eq("run low uio_oe", 32'h0, uio_oe);
      expect_eq("run low halted", 32'h0, halted);
    end
    expect_eq("frames while run low", 32'd0, frame_cnt);

    run = 1'b1;
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
    repeat (QUIET_CYCLES) @(negedge clk);  // Any further frame is flagged by the model
    expect_eq("frame count", N_FRAMES, frame_cnt);
    expect_eq("store count", N_STORES, obs_st_addr.size());

    for (i = 0; i < N_STORES; i++) begin
      if (i < obs_st_addr.size()) begin
        expect_eq($sformatf("store %0d addr", i), exp_st_addr[i], obs_st_addr[i]);
        expect_eq($sformatf("store %0d data", i), exp_st_data[i], obs_st_data[i]);
      end
    end

    $display("Errors: %0d, stores: %0d", errors, obs_st_addr.size());
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_handler_top.f */
+incdir+src
src/cpu_bus_pkg.sv
src/cpu_mem_if.sv
src/accum_core.sv
src/byte_bus_sequencer.sv
src/cpu_handler_top.sv
bench/tb_clock_gen.sv
bench/cpu_handler_properties.sv
bench/cpu_handler_tb.sv
